//--- design/alu_pkg.sv
// ALU package: data widths, operation encoding and SIMD word layout
`default_nettype none

package alu_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN      = 32;
  localparam int unsigned SHAMT_W   = 5;
  localparam int unsigned LANE_W    = 8;
  localparam int unsigned NUM_LANES = XLEN / LANE_W;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [LANE_W-1:0] lane_t;

  // --------------------------------------------------------------------------
  // Operations
  // --------------------------------------------------------------------------
  typedef enum logic [4:0] {
    // Add and subtract
    ADD,
    SUB,
    // Bitwise logic
    ANDL,
    ORL,
    XORL,
    // Shifts
    SLL,
    SRL,
    SRA,
    // Set less than
    SLTS,
    SLTU,
    // Branch compares, flag only
    EQ,
    NE,
    LTS,
    LTU,
    GES,
    GEU,
    // Packed SIMD
    ADD8,
    SUB8,
    ADD16,
    SUB16
  } alu_op_e;

  // --------------------------------------------------------------------------
  // SIMD word
  // --------------------------------------------------------------------------
  // One data word seen either flat or as byte lanes, lane 0 in bits 7:0
  typedef union packed {
    xlen_t                     word;
    lane_t [NUM_LANES-1:0]     lane;
  } simd_word_u;

endpackage

`default_nettype wire

//--- design/alu_req_if.sv
// ALU request bundle: accepted operation and operands fanned out to the units
`default_nettype none
`timescale 1ns/100ps

interface alu_req_if
  import alu_pkg::*;
();

  // High for one cycle per accepted request
  logic    fire;
  alu_op_e op;
  xlen_t   operand_a;
  xlen_t   operand_b;

  // Driven by the top level from its ports
  modport source (
    output fire,
    output op,
    output operand_a,
    output operand_b
  );

  // Execution units and the result stage only listen
  modport unit (
    input fire,
    input op,
    input operand_a,
    input operand_b
  );

endinterface

`default_nettype wire

//--- design/alu_adder.sv
// ALU adder: add/subtract, signed and unsigned compare, branch resolution
`default_nettype none
`timescale 1ns/100ps

module alu_adder
  import alu_pkg::*;
(
  alu_req_if.unit req,
  output xlen_t   sum_o,
  output logic    less_o,
  output logic    branch_res_o
);

  logic          negate_b;
  logic          signed_cmp;
  logic [XLEN:0] adder_in_a;
  logic [XLEN:0] adder_in_b;
  logic [XLEN:0] adder_ext;
  logic          zero_flag;

  // Compares for EQ/NE go through the subtractor
  always_comb begin
    negate_b = 1'b0;
    case (req.op)
      SUB, EQ, NE: negate_b = 1'b1;
      default:     negate_b = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Adder
  // --------------------------------------------------------------------------
  // Extra low bit turns inverted B into two's complement
  assign adder_in_a = {req.operand_a, 1'b1};
  assign adder_in_b = {req.operand_b, 1'b0} ^ {(XLEN + 1){negate_b}};
  assign adder_ext  = adder_in_a + adder_in_b;
  assign sum_o      = adder_ext[XLEN:1];
  assign zero_flag  = ~|sum_o;

  // --------------------------------------------------------------------------
  // Compare
  // --------------------------------------------------------------------------
  assign signed_cmp = (req.op == SLTS) || (req.op == LTS) || (req.op == GES);

  // One extra top bit holds the sign, or zero for unsigned compares
  assign less_o = $signed({signed_cmp & req.operand_a[XLEN-1], req.operand_a}) <
                  $signed({signed_cmp & req.operand_b[XLEN-1], req.operand_b});

  // Non-branch operations report taken
  always_comb begin
    case (req.op)
      EQ:       branch_res_o = zero_flag;
      NE:       branch_res_o = ~zero_flag;
      LTS, LTU: branch_res_o = less_o;
      GES, GEU: branch_res_o = ~less_o;
      default:  branch_res_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- design/alu_shifter.sv
// ALU shifter: logical/arithmetic right shift, left shift by bit reversal
`default_nettype none
`timescale 1ns/100ps

module alu_shifter
  import alu_pkg::*;
(
  alu_req_if.unit req,
  output xlen_t   shift_result_o
);

  logic          shift_left;
  logic          shift_arith;
  xlen_t         operand_a_rev;
  xlen_t         shift_op_a;
  logic [XLEN:0] shift_op_ext;
  logic [XLEN:0] shift_right_result;
  xlen_t         shift_left_result;

  assign shift_left  = (req.op == SLL);
  assign shift_arith = (req.op == SRA);

  // Bit reversal on the way in and on the way out
  for (genvar k = 0; k < XLEN; k++) begin : gen_rev
    assign operand_a_rev[k]     = req.operand_a[XLEN-1-k];
    assign shift_left_result[k] = shift_right_result[XLEN-1-k];
  end

  assign shift_op_a = shift_left ? operand_a_rev : req.operand_a;

  // Top bit is the fill value, sign only for SRA
  assign shift_op_ext = {shift_arith & shift_op_a[XLEN-1], shift_op_a};

  // Single right shifter, amount from low bits of B
  assign shift_right_result =
    $unsigned($signed(shift_op_ext) >>> req.operand_b[SHAMT_W-1:0]);

  assign shift_result_o = shift_left ? shift_left_result
                                     : shift_right_result[XLEN-1:0];

endmodule

`default_nettype wire

//--- design/alu_simd_adder.sv
// ALU packed SIMD adder: byte lanes with carry chaining for halfword ops
`default_nettype none
`timescale 1ns/100ps

module alu_simd_adder
  import alu_pkg::*;
(
  alu_req_if.unit req,
  output xlen_t   simd_result_o
);

  logic       negate_b;
  logic       half_lanes;
  simd_word_u op_a;
  simd_word_u op_b;
  simd_word_u sum;

  // Lane size and subtract select
  always_comb begin
    negate_b   = 1'b0;
    half_lanes = 1'b0;
    case (req.op)
      SUB8:    negate_b = 1'b1;
      ADD16:   half_lanes = 1'b1;
      SUB16: begin
        negate_b   = 1'b1;
        half_lanes = 1'b1;
      end
      default: ;
    endcase
  end

  assign op_a.word = req.operand_a;
  assign op_b.word = req.operand_b;

  // --------------------------------------------------------------------------
  // Lane adders
  // --------------------------------------------------------------------------
  // Odd lanes take the carry of the lane below in halfword mode.
  // Even lanes always start fresh, so lane 1 never feeds lane 2.
  always_comb begin : lane_chain
    logic [LANE_W:0] lane_sum;
    lane_t           b_lane;
    logic            carry;
    logic            cin;
    carry    = 1'b0;
    sum.word = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      b_lane = op_b.lane[i] ^ {LANE_W{negate_b}};
      if (half_lanes && (i % 2 == 1)) begin
        cin = carry;
      end else begin
        cin = negate_b;
      end
      lane_sum    = {1'b0, op_a.lane[i]} + {1'b0, b_lane} + {{LANE_W{1'b0}}, cin};
      sum.lane[i] = lane_sum[LANE_W-1:0];
      carry       = lane_sum[LANE_W];
    end
  end

  assign simd_result_o = sum.word;

endmodule

`default_nettype wire

//--- design/alu_result_stage.sv
// ALU result stage: logic ops, result select and registered valid/ready output
`default_nettype none
`timescale 1ns/100ps

module alu_result_stage
  import alu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  alu_req_if.unit req,
  // Unit results
  input  xlen_t   sum_i,
  input  logic    less_i,
  input  logic    branch_res_i,
  input  xlen_t   shift_result_i,
  input  xlen_t   simd_result_i,
  // Output handshake
  input  logic    ready_i,
  output logic    ready_o,
  output logic    valid_o,
  output xlen_t   result_o,
  output logic    branch_res_o
);

  xlen_t result_d;
  xlen_t result_q;
  logic  branch_res_q;
  logic  valid_q;

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  always_comb begin
    result_d = '0;
    case (req.op)
      ANDL: result_d = req.operand_a & req.operand_b;
      ORL:  result_d = req.operand_a | req.operand_b;
      XORL: result_d = req.operand_a ^ req.operand_b;

      ADD, SUB: result_d = sum_i;

      SLL, SRL, SRA: result_d = shift_result_i;

      // Zero-extended compare bit
      SLTS, SLTU: result_d = {{(XLEN - 1){1'b0}}, less_i};

      ADD8, SUB8, ADD16, SUB16: result_d = simd_result_i;

      // Branch compares only set the flag
      default: result_d = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Output register
  // --------------------------------------------------------------------------
  // Room when empty or drained this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req.fire) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on an accepted request
  always_ff @(posedge clk_i) begin
    if (req.fire) begin
      result_q     <= result_d;
      branch_res_q <= branch_res_i;
    end
  end

  assign valid_o      = valid_q;
  assign result_o     = result_q;
  assign branch_res_o = branch_res_q;

endmodule

`default_nettype wire

//--- design/alu_top.sv
// ALU top level: request handshake wiring and execution unit instances
`default_nettype none
`timescale 1ns/100ps

module alu_top
  import alu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Request side
  input  logic    valid_i,
  output logic    ready_o,
  input  alu_op_e op_i,
  input  xlen_t   operand_a_i,
  input  xlen_t   operand_b_i,
  // Response side
  output logic    valid_o,
  input  logic    ready_i,
  output xlen_t   result_o,
  output logic    branch_res_o
);

  // Unit results into the output stage
  xlen_t sum;
  logic  less;
  logic  branch_res;
  xlen_t shift_result;
  xlen_t simd_result;

  alu_req_if req ();

  // Accept when the output stage has room
  assign req.fire      = valid_i & ready_o;
  assign req.op        = op_i;
  assign req.operand_a = operand_a_i;
  assign req.operand_b = operand_b_i;

  // --------------------------------------------------------------------------
  // Execution units
  // --------------------------------------------------------------------------
  alu_adder u_adder (
    .req          (req),
    .sum_o        (sum),
    .less_o       (less),
    .branch_res_o (branch_res)
  );

  alu_shifter u_shifter (
    .req            (req),
    .shift_result_o (shift_result)
  );

  alu_simd_adder u_simd_adder (
    .req           (req),
    .simd_result_o (simd_result)
  );

  // --------------------------------------------------------------------------
  // Result select and output register
  // --------------------------------------------------------------------------
  alu_result_stage u_result_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req            (req),
    .sum_i          (sum),
    .less_i         (less),
    .branch_res_i   (branch_res),
    .shift_result_i (shift_result),
    .simd_result_i  (simd_result),
    .ready_i        (ready_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .result_o       (result_o),
    .branch_res_o   (branch_res_o)
  );

endmodule

`default_nettype wire

//--- bench/alu_properties.sv
// ALU output stage assertions: reset state, stall stability and ready rule
`default_nettype none
`timescale 1ns/100ps

module alu_properties
  import alu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  fire_i,
  input  logic  ready_i,
  input  logic  ready_o,
  input  logic  valid_o,
  input  xlen_t result_o,
  input  logic  branch_res_o
);

  // Output register empty while reset is held
  valid_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !valid_o)
    else $error("valid_o is high while reset is asserted");

  // Held result must not move while the consumer stalls
  result_stable_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(result_o) && $stable(branch_res_o)))
    else $error("Result changed or was dropped while stalled");

  // With room offered, the old entry is gone next cycle and only a new request refills it
  ready_rule: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ready_o |=> (valid_o == $past(fire_i)))
    else $error("Output register did not empty or refill as ready_o promised");

endmodule

bind alu_result_stage alu_properties u_properties (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .fire_i       (req.fire),
  .ready_i      (ready_i),
  .ready_o      (ready_o),
  .valid_o      (valid_o),
  .result_o     (result_o),
  .branch_res_o (branch_res_o)
);

`default_nettype wire

//--- bench/alu_tb.sv
// ALU testbench: directed tests, in-order reference checks, random mix and watchdog
`default_nettype none
`timescale 1ns/100ps

module alu_tb
  import alu_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  // Requests issued by all tests together, sets the watchdog limit
  localparam int TOTAL_REQS  = 8 + 30 + 23 + 8 + 13 + 200;

  logic    clk_i;
  logic    rst_n_i;
  logic    valid_i;
  logic    ready_o;
  alu_op_e op_i;
  xlen_t   operand_a_i;
  xlen_t   operand_b_i;
  logic    valid_o;
  logic    ready_i;
  xlen_t   result_o;
  logic    branch_res_o;

  xlen_t   exp_word_q [$];
  logic    exp_flag_q [$];
  string   cur_test = "reset";
  int      word_errs = 0;
  int      flag_errs = 0;
  int      other_errs = 0;
  logic    rand_ready;
  xlen_t   ready_bits;
  xlen_t   lcg_state = 32'h8414_1bf3;

  alu_top DUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .result_o     (result_o),
    .branch_res_o (branch_res_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------------
  function automatic xlen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic xlen_t ref_result(input alu_op_e op, input xlen_t a, input xlen_t b);
    xlen_t              r;
    logic [SHAMT_W-1:0] sh;
    sh = b[SHAMT_W-1:0];
    r  = '0;
    case (op)
      ADD:  r = a + b;
      SUB:  r = a - b;
      ANDL: r = a & b;
      ORL:  r = a | b;
      XORL: r = a ^ b;
      SLL:  r = a << sh;
      SRL:  r = a >> sh;
      SRA:  r = $signed(a) >>> sh;
      SLTS: r[0] = $signed(a) < $signed(b);
      SLTU: r[0] = a < b;
      // Each byte wraps on its own
      ADD8, SUB8: begin
        for (int i = 0; i < NUM_LANES; i++) begin
          r[LANE_W*i +: LANE_W] = (op == ADD8) ? a[LANE_W*i +: LANE_W] + b[LANE_W*i +: LANE_W]
                                               : a[LANE_W*i +: LANE_W] - b[LANE_W*i +: LANE_W];
        end
      end
      ADD16, SUB16: begin
        for (int i = 0; i < 2; i++) begin
          r[16*i +: 16] = (op == ADD16) ? a[16*i +: 16] + b[16*i +: 16]
                                        : a[16*i +: 16] - b[16*i +: 16];
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic ref_branch(input alu_op_e op, input xlen_t a, input xlen_t b);
    case (op)
      EQ:      return a == b;
      NE:      return a != b;
      LTS:     return $signed(a) < $signed(b);
      LTU:     return a < b;
      GES:     return $signed(a) >= $signed(b);
      GEU:     return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      flag_errs++;
    end
  endtask

  // Holds the request until the DUT accepts it
  task automatic send_request(input alu_op_e op, input xlen_t a, input xlen_t b);
    valid_i     = 1'b1;
    op_i        = op;
    operand_a_i = a;
    operand_b_i = b;
    @(negedge clk_i);
    while (!ready_o) @(negedge clk_i);
    exp_word_q.push_back(ref_result(op, a, b));
    exp_flag_q.push_back(ref_branch(op, a, b));
    @(posedge clk_i);
    #DRIVE_DELAY;
    valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_word_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // Completion happens on the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i && valid_o && ready_i) begin
      if (exp_word_q.size() == 0) begin
        $display("The DUT returned a result in %s with no request outstanding", cur_test);
        other_errs++;
      end else begin
        check_word(cur_test, exp_word_q.pop_front(), result_o);
        check_flag(cur_test, exp_flag_q.pop_front(), branch_res_o);
      end
    end
  end

  always @(posedge clk_i) begin
    #DRIVE_DELAY;
    if (rand_ready) begin
      ready_bits = lcg_next();
      ready_i    = ready_bits[16];
    end
  end

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic arith_logic_test();
    cur_test = "arith and logic";
    send_request(ADD, 32'h0000_0005, 32'h0000_0007);
    send_request(ADD, 32'hffff_ffff, 32'h0000_0001);
    send_request(ADD, 32'h7fff_ffff, 32'h0000_0001);
    send_request(SUB, 32'h0000_0003, 32'h0000_0005);
    send_request(SUB, 32'h8000_0000, 32'h0000_0001);
    send_request(ANDL, 32'hf0f0_1234, 32'h0ff0_ff00);
    send_request(ORL, 32'hf0f0_1234, 32'h0ff0_ff00);
    send_request(XORL, 32'hf0f0_1234, 32'h0ff0_ff00);
    wait_idle();
  endtask

  task automatic shift_test();
    alu_op_e sh_ops [3];
    xlen_t   amts [5];
    xlen_t   vals [2];
    cur_test = "shifts";
    sh_ops   = '{SLL, SRL, SRA};
    // 32 and 45 only count through their low five bits
    amts     = '{32'd0, 32'd1, 32'd31, 32'd32, 32'd45};
    vals     = '{32'h8765_4321, 32'h4321_8765};
    foreach (sh_ops[i]) begin
      foreach (amts[j]) begin
        foreach (vals[k]) send_request(sh_ops[i], vals[k], amts[j]);
      end
    end
    wait_idle();
  endtask

  task automatic compare_test();
    alu_op_e br_ops [6];
    cur_test = "compare and branch";
    br_ops   = '{EQ, NE, LTS, LTU, GES, GEU};
    send_request(SLTS, 32'h8000_0000, 32'h0000_0000);
    send_request(SLTU, 32'h8000_0000, 32'h0000_0000);
    send_request(SLTS, 32'h0000_0000, 32'h8000_0000);
    send_request(SLTU, 32'h0000_0000, 32'h8000_0000);
    foreach (br_ops[i]) begin
      send_request(br_ops[i], 32'h0000_1234, 32'h0000_1234);
      send_request(br_ops[i], 32'hffff_fff0, 32'h0000_0010);
      send_request(br_ops[i], 32'h0000_0010, 32'hffff_fff0);
    end
    send_request(ADD, 32'h0000_0001, 32'h0000_0002);
    wait_idle();
  endtask

  task automatic simd_test();
    cur_test = "simd lanes";
    send_request(ADD8, 32'hff80_7f01, 32'h0180_0101);
    send_request(ADD8, 32'h00ff_00ff, 32'h0001_0001);
    send_request(SUB8, 32'h0001_0000, 32'h0102_0001);
    send_request(SUB8, 32'h8000_7f00, 32'h0101_0001);
    send_request(ADD16, 32'h00ff_00ff, 32'h0001_0001);
    send_request(ADD16, 32'h0000_ff00, 32'h0000_0100);
    send_request(SUB16, 32'h0100_0100, 32'h0001_0001);
    send_request(SUB16, 32'h0001_0000, 32'h0000_0001);
    wait_idle();
  endtask

  task automatic handshake_test();
    time t0;
    cur_test = "handshake";
    check_flag("handshake idle", 1'b0, valid_o);
    ready_i = 1'b0;
    send_request(ADD, 32'h0000_00aa, 32'h0000_0055);
    @(negedge clk_i);
    check_flag("handshake latency", 1'b1, valid_o);
    repeat (3) begin
      check_word("handshake hold", exp_word_q[0], result_o);
      check_flag("handshake stall ready", 1'b0, ready_o);
      check_flag("handshake stall valid", 1'b1, valid_o);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    ready_i = 1'b1;
    // Back to back stream, one acceptance per cycle
    t0 = $time;
    for (int i = 0; i < 12; i++) send_request(ADD, xlen_t'(i), 32'h0000_1000);
    if ($time - t0 != 64'(12 * CLK_PERIOD)) begin
      $display("A stream of 12 requests was not accepted at one per cycle");
      other_errs++;
    end
    wait_idle();
  endtask

  task automatic random_mix_test();
    xlen_t   r;
    alu_op_e op;
    cur_test   = "random mix";
    rand_ready = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r  = lcg_next();
      op = alu_op_e'(r[20:16] % 5'd20);
      send_request(op, lcg_next(), lcg_next());
    end
    wait_idle();
    rand_ready = 1'b0;
    ready_i    = 1'b1;
  endtask

  // --------------------------------------------------------------------------
  // Sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    ready_i     = 1'b1;
    rand_ready  = 1'b0;
    repeat (3) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("reset valid", 1'b0, valid_o);
    check_flag("reset ready", 1'b1, ready_o);
    @(posedge clk_i);
    #DRIVE_DELAY;
    arith_logic_test();
    shift_test();
    compare_test();
    simd_test();
    handshake_test();
    random_mix_test();
    $display("Errors: %0d word, %0d flag, %0d other", word_errs, flag_errs, other_errs);
    if (word_errs + flag_errs + other_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TOTAL_REQS * 10 * CLK_PERIOD);
    $display("Watchdog expired before all requests completed in %s", cur_test);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/alu_pkg.sv
design/alu_req_if.sv
design/alu_adder.sv
design/alu_shifter.sv
design/alu_simd_adder.sv
design/alu_result_stage.sv
design/alu_top.sv
bench/alu_properties.sv
bench/alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

{ verilator --binary --timing --assert -f verilog.f --top-module alu_tb -o alu_tb_sim \
    && ./obj_dir/alu_tb_sim; } > "$LOG" 2>&1

cat "$LOG"
grep -qx "Test completed successfully" "$LOG" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
